// File: design/decodePkg.sv
package decodePkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction format
	////////////////////////////////////////////////////////////////////////////

	localparam int InstrWidth = 18;
	localparam int DataWidth = 16;
	localparam int RegSelWidth = 4;
	localparam int FlagWidth = 3;

	// Flag bit positions
	localparam int FlagLow = 2;
	localparam int FlagNeg = 1;
	localparam int FlagZero = 0;

	// Registers on write port 2
	localparam logic [RegSelWidth-1:0] SpecialRegLo = 4'd12;
	localparam logic [RegSelWidth-1:0] SpecialRegHi = 4'd13;

	localparam logic [RegSelWidth-1:0] WideDestReg = 4'd11;
	localparam logic [RegSelWidth-1:0] AccumReg = 4'd15;

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		ClsNone, ClsReg, ClsMem, ClsImm, ClsAddr, ClsIncDec
	} instrClassT;

	// 0 and 1 carry no ALU operation
	typedef enum logic [3:0] {
		OpNone = 4'd0, OpAdd = 4'd2, OpSub = 4'd3, OpAnd = 4'd4, OpOr = 4'd5,
		OpXor = 4'd6, OpNot = 4'd7, OpLsh = 4'd8, OpRsh = 4'd9, OpArsh = 4'd10,
		OpFmul = 4'd11, OpMul = 4'd12, OpCmp = 4'd13, OpCmpr = 4'd14, OpMovr = 4'd15
	} aluOpT;

	typedef enum logic [3:0] {
		MemMovMR = 4'd0, MemMovRM = 4'd1
	} memOpT;

	// Bit 0 of the move codes is part of the address
	typedef enum logic [4:0] {
		AddrMovMri = 5'b01000, AddrMovRmi = 5'b01010,
		AddrJ = 5'b01100, AddrJE = 5'b01101, AddrJNE = 5'b01110, AddrJL = 5'b01111,
		AddrJLE = 5'b10000, AddrJB = 5'b10001, AddrJBE = 5'b10010
	} addrOpT;

	typedef enum logic [5:0] {
		IncR = 6'b111100, DecR = 6'b111101
	} incDecOpT;

	typedef enum logic {OperandReg, OperandImm} operandSelT;

	typedef enum logic [2:0] {
		ResNone, ResAlu, ResAluWide, ResMove, ResMem, ResIncDec
	} resultSelT;

	typedef enum logic {PcNext, PcJump} pcSelT;

	// All zero is a no-op
	typedef struct packed {
		aluOpT aluOp;
		operandSelT operandSel;
		resultSelT resultSel;
		pcSelT pcSel;
		logic incDecDown;
		logic writeEn1;
		logic writeEn2;
		logic flagWrite;
		logic memRead;
		logic memWrite;
		logic [RegSelWidth-1:0] destSel;
		logic [RegSelWidth-1:0] destSel2;
		logic [RegSelWidth-1:0] srcSel;
		logic [DataWidth-1:0] immediate;
		logic [DataWidth-1:0] addr;
	} ctlWordT;

endpackage

// File: design/decodeBus.sv
`timescale 1ns/1ps

interface decodeBus;
	import decodePkg::*;

	logic valid;
	logic [InstrWidth-1:0] instr;
	logic [FlagWidth-1:0] flags;
	instrClassT cls;

	modport source (
		output valid,
		output instr,
		output flags,
		output cls
	);

	modport sink (
		input valid,
		input instr,
		input flags,
		input cls
	);

endinterface

// File: design/instrClassify.sv
`timescale 1ns/1ps

module instrClassify (
	input logic clk,
	input logic rst,
	input logic inValid,
	input logic [decodePkg::InstrWidth-1:0] instruction,
	input logic [decodePkg::FlagWidth-1:0] flags,
	decodeBus.source bus
);
	import decodePkg::*;

	logic validQ;
	logic [InstrWidth-1:0] instrQ;
	logic [FlagWidth-1:0] flagsQ;

	always_ff @(posedge clk) begin
		if (rst) begin
			validQ <= 1'b0;
		end else begin
			validQ <= inValid;
		end
	end

	// Flags stay with their instruction
	always_ff @(posedge clk) begin
		instrQ <= instruction;
		flagsQ <= flags;
	end

	always_comb begin
		if (instrQ[17:16] == 2'b00) begin
			if (instrQ[15:12] == 4'd0) begin
				bus.cls = ClsReg;
			end else if (instrQ[15:12] == 4'd1) begin
				bus.cls = ClsMem;
			end else begin
				bus.cls = ClsImm;
			end
		end else if (instrQ[17:16] == 2'b01 || instrQ[17:16] == 2'b10) begin
			bus.cls = ClsAddr;
		end else if (instrQ[17:14] == 4'b1111) begin
			bus.cls = ClsIncDec;
		end else begin
			// Stack group lands here
			bus.cls = ClsNone;
		end
	end

	assign bus.valid = validQ;
	assign bus.instr = instrQ;
	assign bus.flags = flagsQ;

endmodule

// File: design/aluDecode.sv
`timescale 1ns/1ps

module aluDecode (
	decodeBus.sink bus,
	output decodePkg::ctlWordT word
);
	import decodePkg::*;

	logic [3:0] opcode;
	logic [RegSelWidth-1:0] dest;
	logic toPort2;

	// Register form keeps its opcode in the low byte
	assign opcode = (bus.cls == ClsReg) ? bus.instr[7:4] : bus.instr[15:12];
	assign dest = bus.instr[11:8];
	assign toPort2 = (dest == SpecialRegLo) || (dest == SpecialRegHi);

	always_comb begin
		word = '0;
		if (bus.cls == ClsReg || bus.cls == ClsImm) begin
			if (opcode >= OpAdd) begin
				word.aluOp = aluOpT'(opcode);
				word.destSel = dest;
				word.destSel2 = dest;
				if (bus.cls == ClsReg) begin
					word.operandSel = OperandReg;
					word.srcSel = bus.instr[3:0];
				end else begin
					word.operandSel = OperandImm;
					word.srcSel = dest;
					word.immediate = {{(DataWidth-8){1'b0}}, bus.instr[7:0]};
				end

				case (aluOpT'(opcode))
					OpCmp, OpCmpr: begin
						// Flags only
						word.flagWrite = 1'b1;
					end
					OpMul: begin
						word.destSel = WideDestReg;
						if (dest == SpecialRegLo) begin
							word.flagWrite = 1'b1;
							word.writeEn1 = 1'b1;
							word.writeEn2 = 1'b1;
							word.resultSel = ResAluWide;
						end
					end
					OpMovr: begin
						word.resultSel = ResMove;
						word.writeEn1 = !toPort2;
						word.writeEn2 = toPort2;
					end
					default: begin
						word.flagWrite = 1'b1;
						word.resultSel = ResAlu;
						word.writeEn1 = !toPort2;
						word.writeEn2 = toPort2;
					end
				endcase
			end
		end else if (bus.cls == ClsIncDec) begin
			if (bus.instr[17:12] == IncR || bus.instr[17:12] == DecR) begin
				word.srcSel = dest;
				word.destSel = dest;
				word.destSel2 = dest;
				word.resultSel = ResIncDec;
				word.incDecDown = (bus.instr[17:12] == DecR);
				word.writeEn1 = !toPort2;
				word.writeEn2 = toPort2;
			end
		end
	end

endmodule

// File: design/memDecode.sv
`timescale 1ns/1ps

module memDecode (
	decodeBus.sink bus,
	output decodePkg::ctlWordT word
);
	import decodePkg::*;

	memOpT memOp;
	logic [RegSelWidth-1:0] dest;
	logic toPort2;

	assign memOp = memOpT'(bus.instr[7:4]);
	assign dest = bus.instr[11:8];
	assign toPort2 = (dest == SpecialRegLo) || (dest == SpecialRegHi);

	always_comb begin
		word = '0;
		if (bus.cls == ClsMem) begin
			if (memOp == MemMovMR) begin
				word.destSel = dest;
				word.destSel2 = dest;
				word.srcSel = bus.instr[3:0];
				word.memRead = 1'b1;
				word.resultSel = ResMem;
				word.writeEn1 = !toPort2;
				word.writeEn2 = toPort2;
			end else if (memOp == MemMovRM) begin
				word.destSel = dest;
				word.destSel2 = dest;
				word.srcSel = bus.instr[3:0];
				word.memWrite = 1'b1;
			end
		end else if (bus.cls == ClsAddr) begin
			// Bit 13 belongs to the address here
			if ({bus.instr[17:14], 1'b0} == AddrMovMri) begin
				word.addr = {{(DataWidth-14){1'b0}}, bus.instr[13:0]};
				word.destSel = AccumReg;
				word.memRead = 1'b1;
				word.writeEn1 = 1'b1;
				word.resultSel = ResMem;
			end else if ({bus.instr[17:14], 1'b0} == AddrMovRmi) begin
				word.addr = {{(DataWidth-14){1'b0}}, bus.instr[13:0]};
				word.srcSel = AccumReg;
				word.memWrite = 1'b1;
			end
		end
	end

endmodule

// File: design/branchDecode.sv
`timescale 1ns/1ps

module branchDecode (
	decodeBus.sink bus,
	output decodePkg::ctlWordT word
);
	import decodePkg::*;

	logic low;
	logic neg;
	logic zero;
	logic isJump;
	logic taken;

	assign low = bus.flags[FlagLow];
	assign neg = bus.flags[FlagNeg];
	assign zero = bus.flags[FlagZero];

	// Condition table
	always_comb begin
		isJump = 1'b1;
		taken = 1'b0;
		case (addrOpT'(bus.instr[17:13]))
			AddrJ: taken = 1'b1;
			AddrJE: taken = zero;
			AddrJNE: taken = !zero;
			AddrJL: taken = neg;
			AddrJLE: taken = neg || zero;
			AddrJB: taken = low;
			AddrJBE: taken = low || zero;
			default: isJump = 1'b0;
		endcase
	end

	always_comb begin
		word = '0;
		if (bus.cls == ClsAddr && isJump) begin
			word.addr = {{(DataWidth-14){1'b0}}, bus.instr[13:0]};
			word.pcSel = taken ? PcJump : PcNext;
		end
	end

endmodule

// File: design/ctlStage.sv
`timescale 1ns/1ps

module ctlStage (
	input logic clk,
	input logic rst,
	input logic valid,
	input decodePkg::ctlWordT aluWord,
	input decodePkg::ctlWordT memWord,
	input decodePkg::ctlWordT branchWord,
	output logic outValid,
	output decodePkg::ctlWordT ctl
);
	import decodePkg::*;

	ctlWordT merged;

	// Each decoder is zero outside its own classes
	assign merged = ctlWordT'(aluWord | memWord | branchWord);

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
			ctl <= '0;
		end else begin
			outValid <= valid;
			if (valid) begin
				ctl <= merged;
			end else begin
				ctl <= '0;
			end
		end
	end

endmodule

// File: design/decodeTop.sv
`timescale 1ns/1ps

module decodeTop (
	input logic clk,
	input logic rst,
	input logic inValid,
	input logic [decodePkg::InstrWidth-1:0] instruction,
	input logic [decodePkg::FlagWidth-1:0] flags,
	output logic outValid,
	output decodePkg::aluOpT aluOp,
	output decodePkg::operandSelT operandSel,
	output decodePkg::resultSelT resultSel,
	output decodePkg::pcSelT pcSel,
	output logic incDecDown,
	output logic writeEn1,
	output logic writeEn2,
	output logic flagWrite,
	output logic memRead,
	output logic memWrite,
	output logic [decodePkg::RegSelWidth-1:0] destSel,
	output logic [decodePkg::RegSelWidth-1:0] destSel2,
	output logic [decodePkg::RegSelWidth-1:0] srcSel,
	output logic [decodePkg::DataWidth-1:0] immediate,
	output logic [decodePkg::DataWidth-1:0] addr
);
	import decodePkg::*;

	ctlWordT aluWord;
	ctlWordT memWord;
	ctlWordT branchWord;
	ctlWordT ctl;

	decodeBus bus ();

	////////////////////////////////////////////////////////////////////////////
	// Stage one, then the field decoders
	////////////////////////////////////////////////////////////////////////////

	instrClassify classify (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.instruction(instruction),
		.flags(flags),
		.bus(bus.source)
	);

	aluDecode aluDec (.bus(bus.sink), .word(aluWord));
	memDecode memDec (.bus(bus.sink), .word(memWord));
	branchDecode branchDec (.bus(bus.sink), .word(branchWord));

	ctlStage outStage (
		.clk(clk),
		.rst(rst),
		.valid(bus.valid),
		.aluWord(aluWord),
		.memWord(memWord),
		.branchWord(branchWord),
		.outValid(outValid),
		.ctl(ctl)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output fields
	////////////////////////////////////////////////////////////////////////////

	assign aluOp = ctl.aluOp;
	assign operandSel = ctl.operandSel;
	assign resultSel = ctl.resultSel;
	assign pcSel = ctl.pcSel;
	assign incDecDown = ctl.incDecDown;
	assign writeEn1 = ctl.writeEn1;
	assign writeEn2 = ctl.writeEn2;
	assign flagWrite = ctl.flagWrite;
	assign memRead = ctl.memRead;
	assign memWrite = ctl.memWrite;
	assign destSel = ctl.destSel;
	assign destSel2 = ctl.destSel2;
	assign srcSel = ctl.srcSel;
	assign immediate = ctl.immediate;
	assign addr = ctl.addr;

endmodule

// File: sim/tbDecode.sv
`timescale 1ns/1ps

module tbDecode;
	import decodePkg::*;

	localparam int CtlBits = $bits(ctlWordT);

	logic clk;
	logic rst;
	logic inValid;
	logic [InstrWidth-1:0] instruction;
	logic [FlagWidth-1:0] flags;
	logic outValid;
	aluOpT aluOp;
	operandSelT operandSel;
	resultSelT resultSel;
	pcSelT pcSel;
	logic incDecDown;
	logic writeEn1;
	logic writeEn2;
	logic flagWrite;
	logic memRead;
	logic memWrite;
	logic [RegSelWidth-1:0] destSel;
	logic [RegSelWidth-1:0] destSel2;
	logic [RegSelWidth-1:0] srcSel;
	logic [DataWidth-1:0] immediate;
	logic [DataWidth-1:0] addr;

	ctlWordT actWord;
	// Expected words in flight with the valid bit on top
	logic [CtlBits:0] expQ[$];
	logic [31:0] lcgState;
	string curTest;
	int errCount;
	int checkCount;
	int testErrs;
	int testChecks;
	int testsRun;
	int testsFailed;

	decodeTop dut (.*);

	assign actWord = {aluOp, operandSel, resultSel, pcSel, incDecDown, writeEn1, writeEn2,
		flagWrite, memRead, memWrite, destSel, destSel2, srcSel, immediate, addr};

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////////////////////////////////////////////////

	// Upper halves of two LCG steps
	function automatic logic [31:0] lcgNext();
		logic [15:0] hi;
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		hi = lcgState[31:16];
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return {hi, lcgState[31:16]};
	endfunction

	// Kind 0 ALU, 1 memory, 2 inc/dec and stack, 3 jump, 4 any of these
	function automatic logic [InstrWidth-1:0] pickInstr(input int kind);
		logic [31:0] r;
		logic [3:0] d;
		logic [3:0] op;
		logic [1:0] s;
		logic [4:0] jc;
		int k;
		r = lcgNext();
		// Lean toward the port 2 registers
		d = r[20] ? {3'b110, r[21]} : r[11:8];
		k = (kind == 4) ? int'(r[30:29]) : kind;
		case (k)
			0: begin
				if (r[22]) return {6'b000000, d, r[7:4], r[3:0]};
				op = (r[27:24] < 4'd2) ? r[27:24] + 4'd2 : r[27:24];
				return {2'b00, op, d, r[7:0]};
			end
			1: begin
				op = r[23] ? r[7:4] : {3'b000, r[4]};
				if (r[22]) return {6'b000001, d, op, r[3:0]};
				return {3'b010, r[24], r[13:0]};
			end
			2: begin
				if (r[26]) return {4'b1111, r[13:12], d, r[7:0]};
				s = (r[25:24] == 2'b11) ? 2'b00 : r[25:24];
				return {2'b11, s, r[13:12], d, r[7:0]};
			end
			default: begin
				jc = {2'b00, r[27:25]};
				if (jc == 5'd7) jc = 5'd0;
				jc = jc + 5'd12;
				return {jc, r[12:0]};
			end
		endcase
	endfunction

	function automatic ctlWordT expectWord(input logic v, input logic [InstrWidth-1:0] ins,
			input logic [FlagWidth-1:0] fl);
		ctlWordT w;
		logic [RegSelWidth-1:0] d;
		logic [3:0] op;
		logic p2;
		logic taken;
		w = '0;
		d = ins[11:8];
		p2 = (d == 4'd12) || (d == 4'd13);
		op = (ins[15:12] == 4'd0) ? ins[7:4] : ins[15:12];
		taken = 1'b0;
		if (!v) return w;
		if (ins[17:16] == 2'b00 && ins[15:12] != 4'd1) begin
			if (op >= 4'd2) begin
				w.aluOp = aluOpT'(op);
				w.destSel = d;
				w.destSel2 = d;
				w.srcSel = (ins[15:12] == 4'd0) ? ins[3:0] : d;
				if (ins[15:12] != 4'd0) begin
					w.operandSel = OperandImm;
					w.immediate = {8'h00, ins[7:0]};
				end
				if (op <= 4'd11) begin
					w.flagWrite = 1'b1;
					w.resultSel = ResAlu;
					w.writeEn1 = !p2;
					w.writeEn2 = p2;
				end else if (op == 4'd12) begin
					w.destSel = 4'd11;
					w.flagWrite = (d == 4'd12);
					w.writeEn1 = (d == 4'd12);
					w.writeEn2 = (d == 4'd12);
					w.resultSel = (d == 4'd12) ? ResAluWide : ResNone;
				end else if (op == 4'd15) begin
					w.resultSel = ResMove;
					w.writeEn1 = !p2;
					w.writeEn2 = p2;
				end else begin
					w.flagWrite = 1'b1;
				end
			end
		end else if (ins[17:12] == 6'b000001) begin
			if (ins[7:4] <= 4'd1) begin
				w.destSel = d;
				w.destSel2 = d;
				w.srcSel = ins[3:0];
				w.memWrite = ins[4];
				w.memRead = !ins[4];
				w.resultSel = ins[4] ? ResNone : ResMem;
				w.writeEn1 = !ins[4] && !p2;
				w.writeEn2 = !ins[4] && p2;
			end
		end else if (ins[17:14] == 4'b0100) begin
			w.addr = {2'b00, ins[13:0]};
			w.destSel = 4'd15;
			w.memRead = 1'b1;
			w.writeEn1 = 1'b1;
			w.resultSel = ResMem;
		end else if (ins[17:14] == 4'b0101) begin
			w.addr = {2'b00, ins[13:0]};
			w.srcSel = 4'd15;
			w.memWrite = 1'b1;
		end else if (ins[17:16] != 2'b11) begin
			// Flags are low, negative, zero from bit 2 down
			w.addr = {2'b00, ins[13:0]};
			case (ins[17:13])
				5'b01100: taken = 1'b1;
				5'b01101: taken = fl[0];
				5'b01110: taken = !fl[0];
				5'b01111: taken = fl[1];
				5'b10000: taken = fl[1] || fl[0];
				5'b10001: taken = fl[2];
				5'b10010: taken = fl[2] || fl[0];
				default: w.addr = '0;
			endcase
			w.pcSel = taken ? PcJump : PcNext;
		end else if (ins[17:13] == 5'b11110) begin
			w.srcSel = d;
			w.destSel = d;
			w.destSel2 = d;
			w.resultSel = ResIncDec;
			w.incDecDown = ins[12];
			w.writeEn1 = !p2;
			w.writeEn2 = p2;
		end
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Driving and checking
	////////////////////////////////////////////////////////////////////////////

	task automatic checkOutputs();
		logic [CtlBits:0] exp;
		exp = expQ.pop_front();
		checkCount++;
		if ({outValid, actWord} !== exp) begin
			errCount++;
			$display("FAILED %s expected %h actual %h", curTest, exp, {outValid, actWord});
		end
	endtask

	// Inputs already on the pins are captured at this edge
	task automatic driveCycle(input logic v, input logic [InstrWidth-1:0] ins,
			input logic [FlagWidth-1:0] fl);
		@(posedge clk);
		expQ.push_back({inValid, expectWord(inValid, instruction, flags)});
		inValid <= v;
		instruction <= ins;
		flags <= fl;
		@(negedge clk);
		checkOutputs();
	endtask

	task automatic drainPipe();
		int n;
		logic idle;
		n = 0;
		idle = 1'b0;
		while (!idle && n < 16) begin
			driveCycle(1'b0, '0, '0);
			n++;
			idle = (outValid === 1'b0) && (actWord === '0) && (expQ[0][CtlBits] == 1'b0);
		end
		if (!idle) begin
			errCount++;
			$display("%s: pipeline did not drain within 16 cycles", curTest);
		end
	endtask

	task automatic issueRandom(input int kind, input int count, input int validPct);
		int issued;
		logic [31:0] r;
		logic v;
		issued = 0;
		while (issued < count) begin
			r = lcgNext();
			v = (int'(r[31:24]) % 100) < validPct;
			driveCycle(v, pickInstr(kind), r[2:0]);
			if (v) issued++;
		end
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testErrs = errCount;
		testChecks = checkCount;
	endtask

	task automatic finishTest();
		testsRun++;
		if (errCount != testErrs) testsFailed++;
		$display("%s: %0d checks, %0d errors", curTest, checkCount - testChecks,
			errCount - testErrs);
	endtask

	initial begin
		logic [31:0] r;
		clk = 1'b0;
		rst = 1'b1;
		inValid = 1'b0;
		instruction = '0;
		flags = '0;
		lcgState = 32'd57;
		errCount = 0;
		checkCount = 0;
		testsRun = 0;
		testsFailed = 0;

		startTest("reset");
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		checkCount++;
		if ({outValid, actWord} !== '0) begin
			errCount++;
			$display("FAILED reset expected %h actual %h", {(CtlBits + 1){1'b0}},
				{outValid, actWord});
		end
		// Stage one holds an empty slot after reset
		expQ.push_back('0);
		drainPipe();
		finishTest();

		startTest("alu");
		issueRandom(0, 300, 80);
		drainPipe();
		finishTest();

		startTest("memory");
		issueRandom(1, 200, 80);
		drainPipe();
		finishTest();

		// Seven jumps and the unused address codes after them
		startTest("jumps");
		for (int c = 12; c < 24; c++) begin
			for (int f = 0; f < 8; f++) begin
				r = lcgNext();
				driveCycle(1'b1, {5'(c), r[12:0]}, 3'(f));
			end
		end
		drainPipe();
		finishTest();

		startTest("incdec");
		issueRandom(2, 120, 80);
		drainPipe();
		finishTest();

		startTest("latency");
		issueRandom(4, 60, 100);
		issueRandom(4, 100, 70);
		drainPipe();
		finishTest();

		$display("%0d tests, %0d failed, %0d checks, %0d errors", testsRun, testsFailed,
			checkCount, errCount);
		if (errCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: files.f
design/decodePkg.sv
design/decodeBus.sv
design/instrClassify.sv
design/aluDecode.sv
design/memDecode.sv
design/branchDecode.sv
design/ctlStage.sv
design/decodeTop.sv
sim/tbDecode.sv

// File: run.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tbDecode -f files.f

out=$(./obj_dir/VtbDecode)
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"
